// File: flist.f
rtl/dmac_pkg.sv
rtl/dmac_regs.sv
rtl/dmac_fsab_req.sv
rtl/dmac_resp_sync.sv
rtl/dmac_fifo.sv
rtl/dmac_read_ctrl.sv
dv/fsab_mem_model.sv
dv/dmac_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the DMA read engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module dmac_tb -o dmac_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/dmac_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi

if ! grep -q "Test passed" sim.log; then
	echo "no result in log"
	exit 1
fi

exit 0

// File: dv/dmac_tb.sv
// Testbench for the DMA read engine.
// Register access, trigger once, autotrigger wrap, back-pressure and credit starvation.
module dmac_tb import dmac_pkg::*; ();

	logic clk = 1'b0;
	logic fsabi_clk = 1'b0;
	logic rst_b, fsabi_rst_b;
	logic spamo_valid, spamo_r_nw;
	logic [spam_did_w-1:0] spamo_did;
	logic [spam_addr_w-1:0] spamo_addr;
	logic [spam_data_w-1:0] spamo_data, spami_data;
	logic spami_busy_b;
	logic fsabo_valid, fsabo_credit, fsabi_valid;
	logic [fsab_mode_w-1:0] fsabo_mode;
	logic [fsab_did_w-1:0] fsabo_did, fsabo_subdid, fsabi_did, fsabi_subdid;
	logic [fsab_addr_w-1:0] fsabo_addr;
	logic [fsab_len_w-1:0] fsabo_len;
	logic [fsab_data_w-1:0] fsabi_data, pop_data;
	logic pop = 1'b0;
	logic pop_valid, pop_en, starve;
	logic [fifo_level_w-1:0] fifo_level;
	logic [fsab_data_w-1:0] popped[$];
	logic [spam_data_w-1:0] rd;
	int errors = 0, tests_ok = 0, tests_bad = 0, req_count = 0, cycles = 0;
	int err_mark, req_mark, i;

	always #20 clk = ~clk;
	always #14 fsabi_clk = ~fsabi_clk;

	dmac_read_ctrl dmac_read_ctrl_i (.*);

	fsab_mem_model mem_i (.*);

	// expected data word for an address.
	function automatic logic [fsab_data_w-1:0] ref_word(input logic [fsab_addr_w-1:0] addr);
		logic [31:0] lo;
		lo = {1'b0, addr};
		return {~lo, lo};
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (fsabo_valid) begin
			req_count <= req_count + 1;
			check("fsabo_mode", fsabo_mode, fsab_mode_read);
			check("fsabo_len", fsabo_len, 1); // one word per read.
			check("fsabo_did", fsabo_did, dmac_fsab_did);
			check("fsabo_subdid", fsabo_subdid, dmac_fsab_subdid);
		end
		if (pop_valid) popped.push_back(pop_data);
		if (cycles == 20000) begin
			$display("timeout after 20000 cycles, run did not finish");
			$display("Test failed");
			$finish;
		end
	end

	always @(negedge clk) pop <= pop_en; // empty pops are dropped by the DUT.

	task automatic spam_write(input logic [spam_addr_w-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		spamo_valid = 1'b1;
		spamo_r_nw = 1'b0;
		spamo_did = dmac_spam_did;
		spamo_addr = addr;
		spamo_data = data;
		@(negedge clk);
		spamo_valid = 1'b0;
	endtask

	task automatic spam_read(input logic [spam_addr_w-1:0] addr, output logic [31:0] data);
		int n;
		@(negedge clk);
		spamo_valid = 1'b1;
		spamo_r_nw = 1'b1;
		spamo_did = dmac_spam_did;
		spamo_addr = addr;
		n = 0;
		data = 'x;
		@(negedge clk);
		spamo_valid = 1'b0;
		while (!spami_busy_b && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (spami_busy_b) begin
			data = spami_data;
			@(negedge clk);
			if (spami_busy_b) begin
				$display("spami_busy_b stayed high longer than one cycle at offset %h", addr);
				errors++;
			end
		end else begin
			$display("no SPAM read answer at offset %h", addr);
			errors++;
		end
	endtask

	task automatic wait_words(input int n, input int limit);
		int c;
		c = 0;
		while (popped.size() < n && c < limit) begin
			@(negedge clk);
			c++;
		end
		if (popped.size() < n) begin
			$display("only %0d of %0d words arrived", popped.size(), n);
			errors++;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_seq(input logic [30:0] base, input int len);
		foreach (popped[k]) check("pop_data", popped[k], ref_word(base + 31'(8 * (k % len))));
	endtask

	task automatic begin_test();
		err_mark = errors;
		req_mark = req_count;
		popped.delete();
	endtask

	task automatic end_test(input string name);
		if (errors == err_mark) begin
			$display("%s: ok", name);
			tests_ok++;
		end else begin
			$display("%s: %0d errors", name, errors - err_mark);
			tests_bad++;
		end
	endtask

	initial begin
		i = $urandom(32'h2e80_2293);
		rst_b = 1'b0;
		fsabi_rst_b = 1'b0;
		spamo_valid = 1'b0;
		spamo_r_nw = 1'b0;
		spamo_did = '0;
		spamo_addr = '0;
		spamo_data = '0;
		pop_en = 1'b0;
		starve = 1'b0;
		repeat (5) @(negedge clk);
		rst_b = 1'b1;
		fsabi_rst_b = 1'b1;
		idle(3);

		begin_test();
		spam_write(reg_start_addr, 32'h1234_5670);
		spam_write(reg_len, 32'h7);
		spam_write(reg_command, 32'(cmd_stop));
		spam_read(reg_start_addr, rd);
		check("spami_data", rd, 32'h1234_5670);
		spam_read(reg_len, rd);
		check("spami_data", rd, 32'h7);
		spam_read(reg_command, rd);
		check("spami_data", rd, 32'(cmd_stop));
		spam_read(24'h00_000c, rd);
		check("spami_data", rd, 0);
		end_test("register read-back");

		begin_test();
		pop_en = 1'b1;
		spam_write(reg_start_addr, 32'h100);
		spam_write(reg_len, 5);
		spam_write(reg_command, 32'(cmd_trigger_once));
		wait_words(5, 2000);
		idle(200);
		check("word count", popped.size(), 5);
		check("fifo_level", fifo_level, 0);
		check("fsabo_valid count", req_count - req_mark, 5);
		check_seq(31'h100, 5);
		end_test("trigger once");

		begin_test();
		spam_write(reg_start_addr, 32'h40);
		spam_write(reg_len, 3);
		spam_write(reg_command, 32'(cmd_autotrigger));
		wait_words(8, 3000);
		req_mark = req_count;
		spam_write(reg_command, 32'(cmd_stop));
		idle(200);
		check("requests after stop", (req_count - req_mark) <= 1, 1);
		check_seq(31'h40, 3);
		end_test("autotrigger wrap");

		begin_test();
		pop_en = 1'b0;
		spam_write(reg_start_addr, 32'h200);
		spam_write(reg_len, 32);
		spam_write(reg_command, 32'(cmd_autotrigger));
		i = 0;
		while (fifo_level != fifo_level_w'(fifo_depth) && i < 4000) begin
			@(negedge clk);
			i++;
		end
		idle(200);
		check("fifo_level", fifo_level, fifo_depth);
		check("fsabo_valid count", req_count - req_mark, fifo_depth);
		spam_write(reg_command, 32'(cmd_stop));
		pop_en = 1'b1;
		wait_words(fifo_depth, 500);
		idle(50);
		check("word count", popped.size(), fifo_depth);
		check_seq(31'h200, 32);
		end_test("fifo back-pressure");

		begin_test();
		starve = 1'b1;
		spam_write(reg_start_addr, 32'h800);
		spam_write(reg_len, 8);
		spam_write(reg_command, 32'(cmd_autotrigger));
		idle(400);
		check("requests while starved", (req_count - req_mark) <= fsab_initial_credits, 1);
		starve = 1'b0;
		wait_words(12, 3000);
		spam_write(reg_command, 32'(cmd_stop));
		idle(200);
		check_seq(31'h800, 8);
		end_test("credit starvation");

		$display("%0d tests ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: dv/fsab_mem_model.sv
// Behavioural FSAB memory for the DMA testbench.
// Takes read requests on clk, answers on fsabi_clk after a random delay
// and hands credits back unless starved.
module fsab_mem_model import dmac_pkg::*; (
	input  logic                   clk,
	input  logic                   fsabi_clk,
	input  logic                   fsabo_valid,
	input  logic [fsab_did_w-1:0]  fsabo_did,
	input  logic [fsab_did_w-1:0]  fsabo_subdid,
	input  logic [fsab_addr_w-1:0] fsabo_addr,
	input  logic                   starve,
	output logic                   fsabo_credit,
	output logic                   fsabi_valid,
	output logic [fsab_did_w-1:0]  fsabi_did,
	output logic [fsab_did_w-1:0]  fsabi_subdid,
	output logic [fsab_data_w-1:0] fsabi_data
);

	logic [fsab_addr_w+2*fsab_did_w-1:0] req_q[$]; // {did, subdid, addr}.
	logic [fsab_addr_w+2*fsab_did_w-1:0] cur_req;
	int issued = 0;
	int returned = 0;
	int credit_wait = 0;
	int delay = 0;
	logic busy = 1'b0;

	initial begin
		fsabo_credit = 1'b0;
		fsabi_valid = 1'b0;
		fsabi_did = '0;
		fsabi_subdid = '0;
		fsabi_data = '0;
	end

	always @(posedge clk) begin
		if (fsabo_valid) begin
			req_q.push_back({fsabo_did, fsabo_subdid, fsabo_addr});
			issued <= issued + 1;
		end
	end

	// credits come back a few cycles after each request.
	always @(negedge clk) begin
		fsabo_credit <= 1'b0;
		if (!starve && (issued > returned)) begin
			if (credit_wait == 3) begin
				fsabo_credit <= 1'b1;
				returned <= returned + 1;
				credit_wait <= 0;
			end else begin
				credit_wait <= credit_wait + 1;
			end
		end
	end

	always @(posedge fsabi_clk) begin
		fsabi_valid <= 1'b0;
		if (!busy && (req_q.size() != 0)) begin
			cur_req = req_q.pop_front();
			delay = $urandom_range(6, 1);
			busy = 1'b1;
		end else if (busy) begin
			delay = delay - 1;
			if (delay == 0) begin
				busy = 1'b0;
				fsabi_valid <= 1'b1;
				fsabi_did <= cur_req[fsab_addr_w+2*fsab_did_w-1 -: fsab_did_w];
				fsabi_subdid <= cur_req[fsab_addr_w+fsab_did_w-1 -: fsab_did_w];
				// address in both halves, upper half inverted.
				fsabi_data <= {~{1'b0, cur_req[fsab_addr_w-1:0]},
					{1'b0, cur_req[fsab_addr_w-1:0]}};
			end
		end
	end

endmodule

// File: rtl/dmac_read_ctrl.sv
// DMA read engine top level.
// Connects the register file, request sequencer, response crossing and
// the read data queue.
module dmac_read_ctrl import dmac_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_b,
	input  logic                    spamo_valid,
	input  logic                    spamo_r_nw,
	input  logic [spam_did_w-1:0]   spamo_did,
	input  logic [spam_addr_w-1:0]  spamo_addr,
	input  logic [spam_data_w-1:0]  spamo_data,
	output logic                    spami_busy_b,
	output logic [spam_data_w-1:0]  spami_data,
	output logic                    fsabo_valid,
	output logic [fsab_mode_w-1:0]  fsabo_mode,
	output logic [fsab_did_w-1:0]   fsabo_did,
	output logic [fsab_did_w-1:0]   fsabo_subdid,
	output logic [fsab_addr_w-1:0]  fsabo_addr,
	output logic [fsab_len_w-1:0]   fsabo_len,
	input  logic                    fsabo_credit,
	input  logic                    fsabi_clk,
	input  logic                    fsabi_rst_b,
	input  logic                    fsabi_valid,
	input  logic [fsab_did_w-1:0]   fsabi_did,
	input  logic [fsab_did_w-1:0]   fsabi_subdid,
	input  logic [fsab_data_w-1:0]  fsabi_data,
	input  logic                    pop,
	output logic                    pop_valid,
	output logic [fsab_data_w-1:0]  pop_data,
	output logic [fifo_level_w-1:0] fifo_level
);

	logic [fsab_addr_w-1:0] trig_start;
	logic [fsab_addr_w-1:0] trig_len;
	logic                   trigger_auto;
	logic                   trigger_once;
	logic                   stop;
	logic                   req_toggle;
	logic                   resp_done;
	logic [fsab_data_w-1:0] resp_data;

	dmac_regs dmac_regs_i (
		.clk, .rst_b,
		.spamo_valid, .spamo_r_nw, .spamo_did, .spamo_addr, .spamo_data,
		.spami_busy_b, .spami_data,
		.trig_start, .trig_len, .trigger_auto, .trigger_once, .stop
	);

	dmac_fsab_req dmac_fsab_req_i (
		.clk, .rst_b,
		.trig_start, .trig_len, .trigger_auto, .trigger_once, .stop,
		.fsabo_credit, .resp_done, .fifo_level,
		.fsabo_valid, .fsabo_mode, .fsabo_did, .fsabo_subdid, .fsabo_addr, .fsabo_len,
		.req_toggle
	);

	dmac_resp_sync dmac_resp_sync_i (
		.clk, .rst_b, .fsabi_clk, .fsabi_rst_b,
		.fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data,
		.req_toggle, .resp_done, .resp_data
	);

	// each completed read goes straight into the queue.
	dmac_fifo dmac_fifo_i (
		.clk, .rst_b,
		.push      (resp_done),
		.push_data (resp_data),
		.pop, .pop_valid, .pop_data, .fifo_level
	);

endmodule

// File: rtl/dmac_fifo.sv
// Read data queue.
// Circular buffer with a level count and a registered pop port.
module dmac_fifo import dmac_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_b,
	input  logic                    push,
	input  logic [fsab_data_w-1:0]  push_data,
	input  logic                    pop,
	output logic                    pop_valid,
	output logic [fsab_data_w-1:0]  pop_data,
	output logic [fifo_level_w-1:0] fifo_level
);

	logic [fsab_data_w-1:0] mem [fifo_depth];
	logic [fifo_ptr_w-1:0]  wr_ptr;
	logic [fifo_ptr_w-1:0]  rd_ptr;
	logic                   do_push;
	logic                   do_pop;

	assign do_push = push && (fifo_level != fifo_level_w'(fifo_depth));
	assign do_pop = pop && (fifo_level != '0); // empty pops are dropped.

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_level <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   fifo_level <= fifo_level + 1'b1;
				2'b01:   fifo_level <= fifo_level - 1'b1;
				default: ; // both or neither.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (do_pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

endmodule

// File: rtl/dmac_resp_sync.sv
// FSAB response capture and clock crossing.
// Latches matching read data in fsabi_clk and hands completion back to clk
// with a toggle synchronizer.
module dmac_resp_sync import dmac_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_b,
	input  logic                   fsabi_clk,
	input  logic                   fsabi_rst_b,
	input  logic                   fsabi_valid,
	input  logic [fsab_did_w-1:0]  fsabi_did,
	input  logic [fsab_did_w-1:0]  fsabi_subdid,
	input  logic [fsab_data_w-1:0] fsabi_data,
	input  logic                   req_toggle,
	output logic                   resp_done,
	output logic [fsab_data_w-1:0] resp_data
);

	logic resp_match;
	logic req_s1;
	logic req_s2;
	logic resp_hold; // data latched, completion not yet sent.
	logic done_tog;
	logic done_s1;
	logic done_s2;
	logic done_seen;

	assign resp_match = fsabi_valid && (fsabi_did == dmac_fsab_did) &&
		(fsabi_subdid == dmac_fsab_subdid);

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			req_s1 <= 1'b0;
			req_s2 <= 1'b0;
			resp_hold <= 1'b0;
			done_tog <= 1'b0;
		end else begin
			req_s1 <= req_toggle;
			req_s2 <= req_s1;
			// a fast answer waits here until the request toggle has arrived.
			if (resp_hold && (req_s2 != done_tog)) begin
				resp_hold <= 1'b0;
				done_tog <= req_s2;
			end else if (resp_match) begin
				resp_hold <= 1'b1;
			end
		end
	end

	always_ff @(posedge fsabi_clk) begin
		if (resp_match) begin
			resp_data <= fsabi_data;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			done_s1 <= 1'b0;
			done_s2 <= 1'b0;
			done_seen <= 1'b0;
		end else begin
			done_s1 <= done_tog;
			done_s2 <= done_s1;
			done_seen <= done_s2;
		end
	end

	assign resp_done = (done_s2 != done_seen) && (done_s2 == req_toggle);

endmodule

// File: rtl/dmac_fsab_req.sv
// FSAB read request sequencer.
// Walks the address range one word at a time, tracks bus credits and keeps
// at most one read outstanding.
module dmac_fsab_req import dmac_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_b,
	input  logic [fsab_addr_w-1:0]  trig_start,
	input  logic [fsab_addr_w-1:0]  trig_len,
	input  logic                    trigger_auto,
	input  logic                    trigger_once,
	input  logic                    stop,
	input  logic                    fsabo_credit,
	input  logic                    resp_done,
	input  logic [fifo_level_w-1:0] fifo_level,
	output logic                    fsabo_valid,
	output logic [fsab_mode_w-1:0]  fsabo_mode,
	output logic [fsab_did_w-1:0]   fsabo_did,
	output logic [fsab_did_w-1:0]   fsabo_subdid,
	output logic [fsab_addr_w-1:0]  fsabo_addr,
	output logic [fsab_len_w-1:0]   fsabo_len,
	output logic                    req_toggle
);

	logic                      running;
	logic                      auto_mode;
	logic                      pending;
	logic                      restarted; // pending read belongs to an older run.
	logic                      trigger;
	logic                      issue;
	logic                      at_end;
	logic [fsab_credits_w-1:0] credits;
	logic [fsab_addr_w-1:0]    cur_addr;
	logic [fsab_addr_w-1:0]    start_addr;
	logic [fsab_addr_w-1:0]    end_addr;

	assign trigger = (trigger_auto || trigger_once) && (trig_len != '0);
	assign issue = running && !pending && (credits != '0) &&
		(fifo_level < fifo_level_w'(fifo_depth));
	assign at_end = (cur_addr == end_addr);

	assign fsabo_valid = issue;
	assign fsabo_mode = fsab_mode_read;
	assign fsabo_did = dmac_fsab_did;
	assign fsabo_subdid = dmac_fsab_subdid;
	assign fsabo_addr = cur_addr;
	assign fsabo_len = fsab_len_single;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= fsab_initial_credits;
		end else begin
			credits <= credits + fsab_credits_w'(fsabo_credit) - fsab_credits_w'(issue);
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			running <= 1'b0;
			auto_mode <= 1'b0;
			pending <= 1'b0;
			restarted <= 1'b0;
			req_toggle <= 1'b0;
		end else begin
			if (issue) begin
				pending <= 1'b1;
				req_toggle <= ~req_toggle; // one flip per read.
			end else if (resp_done) begin
				pending <= 1'b0;
			end
			if (resp_done) begin
				restarted <= 1'b0;
			end
			if (trigger) begin
				running <= 1'b1;
				auto_mode <= trigger_auto;
				restarted <= (pending || issue) && !resp_done;
			end else if (stop) begin
				running <= 1'b0; // outstanding read still lands.
			end else if (resp_done && !restarted && at_end && !auto_mode) begin
				running <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cur_addr <= '0;
			start_addr <= '0;
			end_addr <= '0;
		end else if (trigger) begin
			cur_addr <= trig_start;
			start_addr <= trig_start;
			end_addr <= trig_start + ((trig_len - fsab_addr_w'(1)) << fsab_word_shift);
		end else if (resp_done && !restarted) begin
			if (at_end) begin
				cur_addr <= start_addr; // wrap, idles in once mode.
			end else begin
				cur_addr <= cur_addr + (fsab_addr_w'(1) << fsab_word_shift);
			end
		end
	end

endmodule

// File: rtl/dmac_regs.sv
// DMA engine register file on the SPAM bus.
// Holds next start address, next length and last command; command writes
// turn into one-cycle trigger or stop pulses.
module dmac_regs import dmac_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_b,
	input  logic                   spamo_valid,
	input  logic                   spamo_r_nw,
	input  logic [spam_did_w-1:0]  spamo_did,
	input  logic [spam_addr_w-1:0] spamo_addr,
	input  logic [spam_data_w-1:0] spamo_data,
	output logic                   spami_busy_b,
	output logic [spam_data_w-1:0] spami_data,
	output logic [fsab_addr_w-1:0] trig_start,
	output logic [fsab_addr_w-1:0] trig_len,
	output logic                   trigger_auto,
	output logic                   trigger_once,
	output logic                   stop
);

	logic             access;
	logic             wr_access;
	logic             rd_access;
	logic             cmd_wr;
	logic [cmd_w-1:0] command; // last command written.
	logic [spam_data_w-1:0] rd_value;

	assign access = spamo_valid && (spamo_did == dmac_spam_did);
	assign wr_access = access && !spamo_r_nw;
	assign rd_access = access && spamo_r_nw;
	assign cmd_wr = wr_access && (spamo_addr == reg_command);

	always_comb begin
		case (spamo_addr)
			reg_start_addr: rd_value = spam_data_w'(trig_start);
			reg_len:        rd_value = spam_data_w'(trig_len);
			reg_command:    rd_value = spam_data_w'(command);
			default:        rd_value = '0; // unmapped offsets.
		endcase
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			trig_start <= '0;
			trig_len <= '0;
			command <= '0;
			trigger_auto <= 1'b0;
			trigger_once <= 1'b0;
			stop <= 1'b0;
			spami_busy_b <= 1'b0;
		end else begin
			trigger_auto <= cmd_wr && (spamo_data == spam_data_w'(cmd_autotrigger));
			trigger_once <= cmd_wr && (spamo_data == spam_data_w'(cmd_trigger_once));
			stop <= cmd_wr && (spamo_data == spam_data_w'(cmd_stop));
			spami_busy_b <= rd_access; // single-cycle read answer.
			if (wr_access) begin
				case (spamo_addr)
					reg_start_addr: trig_start <= spamo_data[fsab_addr_w-1:0];
					reg_len:        trig_len <= spamo_data[fsab_addr_w-1:0];
					reg_command:    command <= spamo_data[cmd_w-1:0];
					default:        ;
				endcase
			end
		end
	end

	// read data register.
	always_ff @(posedge clk) begin
		if (rd_access) begin
			spami_data <= rd_value;
		end
	end

endmodule

// File: rtl/dmac_pkg.sv
// DMA read engine shared definitions.
// Bus widths, device ids, register map, command codes and queue sizing.
package dmac_pkg;

	// FSAB memory bus.
	localparam int fsab_addr_w = 31;
	localparam int fsab_data_w = 64;
	localparam int fsab_len_w = 4;
	localparam int fsab_did_w = 4;
	localparam int fsab_mode_w = 1;
	localparam logic [fsab_mode_w-1:0] fsab_mode_read = 1'b0;
	localparam logic [fsab_len_w-1:0] fsab_len_single = 4'd1; // one 8-byte word.
	localparam int fsab_word_shift = 3; // log2 of bytes per word.

	localparam logic [fsab_did_w-1:0] dmac_fsab_did = 4'd3;
	localparam logic [fsab_did_w-1:0] dmac_fsab_subdid = 4'd1;

	localparam int fsab_credits_w = 3;
	localparam logic [fsab_credits_w-1:0] fsab_initial_credits = 3'd4;

	// SPAM register bus.
	localparam int spam_addr_w = 24;
	localparam int spam_data_w = 32;
	localparam int spam_did_w = 4;
	localparam logic [spam_did_w-1:0] dmac_spam_did = 4'd5;

	localparam logic [spam_addr_w-1:0] reg_start_addr = 24'h00_0000;
	localparam logic [spam_addr_w-1:0] reg_len = 24'h00_0004;
	localparam logic [spam_addr_w-1:0] reg_command = 24'h00_0008;

	localparam int cmd_w = 2;
	localparam logic [cmd_w-1:0] cmd_autotrigger = 2'd0;
	localparam logic [cmd_w-1:0] cmd_trigger_once = 2'd1;
	localparam logic [cmd_w-1:0] cmd_stop = 2'd2;

	// read data queue.
	localparam int fifo_depth = 16;
	localparam int fifo_ptr_w = 4;
	localparam int fifo_level_w = 5;

endpackage
